// File: ulaTimingPkg.sv
`default_nettype none

package ulaTimingPkg;

   //////////////////////////////////////////////////
   // Frame geometry in clk7 ticks and lines
   localparam logic [8:0] hTotal       = 9'd448;
   localparam logic [8:0] vTotal       = 9'd312;
   localparam logic [8:0] paperWidth   = 9'd256;
   localparam logic [8:0] paperHeight  = 9'd192;

   // Paper column x shows up on the pins at hc == x + 13
   localparam logic [8:0] pixelLatency = 9'd13;

   //////////////////////////////////////////////////
   // Sync windows (active low, inclusive bounds)
   localparam logic [8:0] hsyncStart   = 9'd344;
   localparam logic [8:0] hsyncEnd     = 9'd375;
   localparam logic [8:0] vsyncStart   = 9'd248;
   localparam logic [8:0] vsyncEnd     = 9'd251;

   // Frame interrupt
   localparam logic [8:0] intLine      = 9'd248;
   localparam logic [8:0] intStart     = 9'd2;
   localparam logic [8:0] intEnd       = 9'd65;

endpackage

`default_nettype wire

// File: ulaPortPkg.sv
`default_nettype none

package ulaPortPkg;

   //////////////////////////////////////////////////
   // Z80 I/O addresses of the ULAplus ports
   localparam logic [15:0] portUlaPlusAddr = 16'hBF3B;
   localparam logic [15:0] portUlaPlusData = 16'hFF3B;

   //////////////////////////////////////////////////
   // Per-channel intensity levels for the IGRB table
   localparam logic [2:0] colourNone = 3'b000;
   localparam logic [2:0] colourHalf = 3'b101;
   localparam logic [2:0] colourFull = 3'b111;

   // Border after reset is red
   localparam logic [2:0] borderReset = 3'b010;

   // 64 palette entries
   localparam int paletteIndexWidth = 6;

   //////////////////////////////////////////////////
   // Attribute byte as the standard ULA sees it
   typedef struct packed {
      logic       flash;
      logic       bright;
      logic [2:0] paper;
      logic [2:0] ink;
   } attrStd_s;

   // Same byte as ULAplus sees it
   // Top two bits pick one of four 16-entry CLUTs
   typedef struct packed {
      logic [1:0] clut;
      logic [2:0] paper;
      logic [2:0] ink;
   } attrPlus_s;

   typedef union packed {
      attrStd_s  std;
      attrPlus_s plus;
   } attrWord_u;

endpackage

`default_nettype wire

// File: rasterCounter.sv
`timescale 1ns/1ps
`default_nettype none

module rasterCounter (
   input  logic       clk7,
   input  logic       rst_n,
   output logic [8:0] hc,
   output logic [8:0] vc,
   output logic       hsync,
   output logic       vsync,
   output logic       intN
);

   logic lineEnd;
   logic frameEnd;

   // Last tick of a line and last line of a frame
   assign lineEnd  = (hc == ulaTimingPkg::hTotal - 9'd1);
   assign frameEnd = (vc == ulaTimingPkg::vTotal - 9'd1);

   //////////////////////////////////////////////////
   // Horizontal and vertical position
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= 9'd0;
         vc <= 9'd0;
      end else if (lineEnd) begin
         hc <= 9'd0;
         // Line advances together with the hc wrap
         if (frameEnd) begin
            vc <= 9'd0;
         end else begin
            vc <= vc + 9'd1;
         end
      end else begin
         hc <= hc + 9'd1;
      end
   end

   //////////////////////////////////////////////////
   // Sync pulses decoded straight off the counters
   assign hsync = !((hc >= ulaTimingPkg::hsyncStart) && (hc <= ulaTimingPkg::hsyncEnd));
   assign vsync = !((vc >= ulaTimingPkg::vsyncStart) && (vc <= ulaTimingPkg::vsyncEnd));

   // 64-tick INT pulse near the start of the vsync line
   // Two ticks after vsync falls
   assign intN = !((vc == ulaTimingPkg::intLine) &&
                   (hc >= ulaTimingPkg::intStart) &&
                   (hc <= ulaTimingPkg::intEnd));

endmodule

`default_nettype wire

// File: videoFetch.sv
`timescale 1ns/1ps
`default_nettype none

module videoFetch (
   input  logic                  clk7,
   input  logic                  rst_n,
   input  logic [8:0]            hc,
   input  logic [8:0]            vc,
   input  logic [2:0]            border,
   input  logic [7:0]            vramData,
   output logic [13:0]           va,
   output logic                  pixel,
   output ulaPortPkg::attrWord_u attrNext,
   output ulaPortPkg::attrWord_u attrOut,
   output logic                  attrLoad
);

   logic                  fetchWindow;
   logic                  videoEnable;
   logic                  caLoad;
   logic                  bitmapAddr;
   logic                  bitmapLoad;
   logic                  attrAddr;
   logic                  attrDataLoad;
   logic                  serializerLoad;
   logic [4:0]            ca;
   logic [7:0]            bitmapData;
   ulaPortPkg::attrWord_u attrData;
   logic [7:0]            serializer;
   logic [4:0]            flashCount;

   //////////////////////////////////////////////////
   // Control unit
   always_comb begin
      // Fetches run over hc 0..255 of paper lines
      fetchWindow = (hc < ulaTimingPkg::paperWidth) && (vc < ulaTimingPkg::paperHeight);
      // Display trails the fetch by 8 ticks
      videoEnable = (hc >= 9'd8) && (hc < ulaTimingPkg::paperWidth + 9'd8) &&
                    (vc < ulaTimingPkg::paperHeight);
      caLoad      = (hc[2:0] == 3'd3);
      attrLoad    = (hc[2:0] == 3'd4);
      serializerLoad = videoEnable && attrLoad;
      // Offsets 8,9,12,13 of each 16-tick group address the bitmap
      bitmapAddr  = fetchWindow && hc[3] && !hc[1];
      // Offsets 10,11,14,15 address the attribute
      attrAddr    = fetchWindow && hc[3] && hc[1];
      // Data captured on the second tick of each address pair
      bitmapLoad  = bitmapAddr && hc[0];
      attrDataLoad = attrAddr && hc[0];
   end

   // Column address
   always_ff @(posedge clk7) begin
      if (caLoad) begin
         ca <= hc[7:3];
      end
   end

   // Standard screen layout with the page bit tied low
   always_comb begin
      if (bitmapAddr) begin
         va = {1'b0, vc[7:6], vc[2:0], vc[5:3], ca};
      end else if (attrAddr) begin
         va = {1'b0, 3'b110, vc[7:3], ca};
      end else begin
         va = 14'h0000;
      end
   end

   //////////////////////////////////////////////////
   // Datapath
   always_ff @(posedge clk7) begin
      if (bitmapLoad) begin
         bitmapData <= vramData;
      end
      if (attrDataLoad) begin
         attrData <= vramData;
      end
   end

   // Pixel shifter MSB first
   always_ff @(posedge clk7) begin
      if (serializerLoad) begin
         serializer <= bitmapData;
      end else begin
         serializer <= {serializer[6:0], 1'b0};
      end
   end

   // Border shows as paper outside the window
   always_comb begin
      if (videoEnable) begin
         attrNext = attrData;
      end else begin
         attrNext = {2'b00, border, 3'b000};
      end
   end

   always_ff @(posedge clk7) begin
      if (attrLoad) begin
         attrOut <= attrNext;
      end
   end

   // Flash phase steps once a frame
   // Bit 4 toggles every 16 frames
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCount <= 5'd0;
      end else if ((vc == ulaTimingPkg::intLine) && (hc == 9'd0)) begin
         flashCount <= flashCount + 5'd1;
      end
   end

   assign pixel = serializer[7] ^ (attrOut.std.flash & flashCount[4]);

endmodule

`default_nettype wire

// File: colourPalette.sv
`timescale 1ns/1ps
`default_nettype none

module colourPalette (
   input  logic                                      clk7,
   input  logic [8:0]                                hc,
   input  logic                                      pixel,
   input  ulaPortPkg::attrWord_u                     attrNext,
   input  ulaPortPkg::attrWord_u                     attrOut,
   input  logic                                      attrLoad,
   input  logic                                      paletteWrite,
   input  logic [ulaPortPkg::paletteIndexWidth-1:0]  paletteIndex,
   input  logic [7:0]                                din,
   input  logic                                      ulaPlusEnabled,
   output logic [7:0]                                paletteEntry,
   output logic [2:0]                                r,
   output logic [2:0]                                g,
   output logic [2:0]                                b
);

   logic [7:0] paletteRam [0:(1 << ulaPortPkg::paletteIndexWidth) - 1];
   logic [ulaPortPkg::paletteIndexWidth-1:0] paperAddr;
   logic [ulaPortPkg::paletteIndexWidth-1:0] inkAddr;
   logic [7:0] plusPaper;
   logic [7:0] plusInk;
   logic [7:0] plusColour;
   logic [8:0] plusGrb;
   logic [2:0] stdIndex;
   logic [2:0] stdLevel;
   logic [8:0] stdGrb;
   logic       blank;
   logic [8:0] finalGrb;

   //////////////////////////////////////////////////
   // Standard IGRB path
   // Ink or paper index after flash
   assign stdIndex = pixel ? attrOut.std.ink : attrOut.std.paper;

   // Bright lifts every lit channel to full
   assign stdLevel = attrOut.std.bright ? ulaPortPkg::colourFull : ulaPortPkg::colourHalf;

   // G R B from index bits 2 1 0
   // Black has no lit channel so bright black stays black
   assign stdGrb = {stdIndex[2] ? stdLevel : ulaPortPkg::colourNone,
                    stdIndex[1] ? stdLevel : ulaPortPkg::colourNone,
                    stdIndex[0] ? stdLevel : ulaPortPkg::colourNone};

   //////////////////////////////////////////////////
   // ULAplus palette
   // GGGRRRBB entries written from the data port
   always_ff @(posedge clk7) begin
      if (paletteWrite) begin
         paletteRam[paletteIndex] <= din;
      end
   end

   // CPU readback
   assign paletteEntry = paletteRam[paletteIndex];

   // Paper sits in the upper half of each 16-entry CLUT
   assign paperAddr = {attrNext.plus.clut, 1'b1, attrNext.plus.paper};
   assign inkAddr   = {attrNext.plus.clut, 1'b0, attrNext.plus.ink};

   // Looked up one stage early and loaded with attrOut
   always_ff @(posedge clk7) begin
      if (attrLoad) begin
         plusPaper <= paletteRam[paperAddr];
         plusInk   <= paletteRam[inkAddr];
      end
   end

   assign plusColour = pixel ? plusInk : plusPaper;

   // Blue B1 B0 widened to B1 B0 B1
   assign plusGrb = {plusColour, plusColour[1]};

   //////////////////////////////////////////////////
   // Output select
   // Black during the hsync window
   assign blank = (hc >= ulaTimingPkg::hsyncStart) && (hc <= ulaTimingPkg::hsyncEnd);

   always_comb begin
      if (blank) begin
         finalGrb = {3{ulaPortPkg::colourNone}};
      end else if (ulaPlusEnabled) begin
         finalGrb = plusGrb;
      end else begin
         finalGrb = stdGrb;
      end
   end

   assign g = finalGrb[8:6];
   assign r = finalGrb[5:3];
   assign b = finalGrb[2:0];

endmodule

`default_nettype wire

// File: cpuPorts.sv
`timescale 1ns/1ps
`default_nettype none

module cpuPorts (
   input  logic                                      clk7,
   input  logic                                      rst_n,
   input  logic [15:0]                               a,
   input  logic                                      iorqN,
   input  logic                                      rdN,
   input  logic                                      wrN,
   input  logic [7:0]                                din,
   input  logic                                      ear,
   input  logic [4:0]                                kbd,
   input  logic                                      issue2Keyboard,
   input  logic [7:0]                                paletteEntry,
   output logic [7:0]                                dout,
   output logic [2:0]                                border,
   output logic                                      mic,
   output logic                                      spk,
   output logic                                      paletteWrite,
   output logic [ulaPortPkg::paletteIndexWidth-1:0]  paletteIndex,
   output logic                                      ulaPlusEnabled
);

   logic       ioWrite;
   logic       ioRead;
   logic       ulaSel;
   logic       plusAddrSel;
   logic       plusDataSel;
   logic [6:0] paletteReg;
   logic [1:0] configReg;
   logic       processedEar;

   //////////////////////////////////////////////////
   // Address decode
   assign ioWrite = !iorqN && !wrN;
   assign ioRead  = !iorqN && !rdN;

   // Any even address hits the ULA
   assign ulaSel = !a[0];
   // Both ULAplus ports are odd so they never overlap 0xFE
   assign plusAddrSel = (a == ulaPortPkg::portUlaPlusAddr);
   assign plusDataSel = (a == ulaPortPkg::portUlaPlusData);

   //////////////////////////////////////////////////
   // Write registers
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border     <= ulaPortPkg::borderReset;
         mic        <= 1'b0;
         spk        <= 1'b0;
         paletteReg <= 7'd0;
         configReg  <= 2'd0;
      end else if (ioWrite) begin
         if (ulaSel) begin
            border <= din[2:0];
            mic    <= din[3];
            spk    <= din[4];
         end else if (plusAddrSel) begin
            paletteReg <= din[6:0];
         end else if (plusDataSel && paletteReg[6]) begin
            // Group bit set selects the mode register
            configReg <= din[1:0];
         end
      end
   end

   // Palette RAM write in the same edge
   assign paletteWrite   = ioWrite && plusDataSel && !paletteReg[6];
   assign paletteIndex   = paletteReg[5:0];
   assign ulaPlusEnabled = configReg[0];

   //////////////////////////////////////////////////
   // Read mux
   // Issue 2 boards also leak MIC onto EAR
   always_comb begin
      if (issue2Keyboard) begin
         processedEar = ear ^ (spk | mic);
      end else begin
         processedEar = ear ^ spk;
      end
   end

   always_comb begin
      dout = 8'hFF;
      if (ioRead) begin
         if (ulaSel) begin
            dout = {1'b1, processedEar, 1'b1, kbd};
         end else if (plusAddrSel) begin
            dout = {1'b0, paletteReg};
         end else if (plusDataSel) begin
            if (paletteReg[6]) begin
               dout = {6'd0, configReg};
            end else begin
               dout = paletteEntry;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: ulaPlusTop.sv
`timescale 1ns/1ps
`default_nettype none

module ulaPlusTop (
   input  logic        clk7,
   input  logic        rst_n,
   // Z80 side
   input  logic [15:0] a,
   input  logic        iorqN,
   input  logic        rdN,
   input  logic        wrN,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   output logic        intN,
   // Video RAM
   output logic [13:0] va,
   input  logic [7:0]  vramData,
   // Tape and keyboard
   input  logic        ear,
   input  logic [4:0]  kbd,
   input  logic        issue2Keyboard,
   output logic        mic,
   output logic        spk,
   // Video out
   output logic [2:0]  r,
   output logic [2:0]  g,
   output logic [2:0]  b,
   output logic        hsync,
   output logic        vsync
);

   logic [8:0]                               hc;
   logic [8:0]                               vc;
   logic [2:0]                               border;
   logic                                     paletteWrite;
   logic [ulaPortPkg::paletteIndexWidth-1:0] paletteIndex;
   logic                                     ulaPlusEnabled;
   logic [7:0]                               paletteEntry;
   logic                                     pixel;
   ulaPortPkg::attrWord_u                    attrNext;
   ulaPortPkg::attrWord_u                    attrOut;
   logic                                     attrLoad;

   //////////////////////////////////////////////////
   // Raster timing
   rasterCounter raster0 (
      .clk7  (clk7),
      .rst_n (rst_n),
      .hc    (hc),
      .vc    (vc),
      .hsync (hsync),
      .vsync (vsync),
      .intN  (intN)
   );

   // Screen fetch and pixel shifter
   videoFetch fetch0 (
      .clk7     (clk7),
      .rst_n    (rst_n),
      .hc       (hc),
      .vc       (vc),
      .border   (border),
      .vramData (vramData),
      .va       (va),
      .pixel    (pixel),
      .attrNext (attrNext),
      .attrOut  (attrOut),
      .attrLoad (attrLoad)
   );

   // Colour generation
   colourPalette palette0 (
      .clk7           (clk7),
      .hc             (hc),
      .pixel          (pixel),
      .attrNext       (attrNext),
      .attrOut        (attrOut),
      .attrLoad       (attrLoad),
      .paletteWrite   (paletteWrite),
      .paletteIndex   (paletteIndex),
      .din            (din),
      .ulaPlusEnabled (ulaPlusEnabled),
      .paletteEntry   (paletteEntry),
      .r              (r),
      .g              (g),
      .b              (b)
   );

   //////////////////////////////////////////////////
   // CPU I/O ports
   cpuPorts ports0 (
      .clk7           (clk7),
      .rst_n          (rst_n),
      .a              (a),
      .iorqN          (iorqN),
      .rdN            (rdN),
      .wrN            (wrN),
      .din            (din),
      .ear            (ear),
      .kbd            (kbd),
      .issue2Keyboard (issue2Keyboard),
      .paletteEntry   (paletteEntry),
      .dout           (dout),
      .border         (border),
      .mic            (mic),
      .spk            (spk),
      .paletteWrite   (paletteWrite),
      .paletteIndex   (paletteIndex),
      .ulaPlusEnabled (ulaPlusEnabled)
   );

endmodule

`default_nettype wire

// File: ulaPlus_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ulaPlusProperties (
   input logic       clk7,
   input logic       rst_n,
   input logic [8:0] hc,
   input logic [8:0] vc,
   input logic       intN,
   input logic       hsync,
   input logic       vsync,
   input logic       iorqN,
   input logic [7:0] dout
);

   //////////////////////////////////////////////////
   // INT only inside its window on the INT line
   assert property (@(posedge clk7) disable iff (!rst_n)
      !intN |-> (vc == ulaTimingPkg::intLine) &&
                (hc >= ulaTimingPkg::intStart) && (hc <= ulaTimingPkg::intEnd))
      else $error("intN low outside the interrupt window");

   // Sync pulses
   assert property (@(posedge clk7) disable iff (!rst_n)
      !hsync |-> (hc >= ulaTimingPkg::hsyncStart) && (hc <= ulaTimingPkg::hsyncEnd))
      else $error("hsync low outside its window");

   assert property (@(posedge clk7) disable iff (!rst_n)
      !vsync |-> (vc >= ulaTimingPkg::vsyncStart) && (vc <= ulaTimingPkg::vsyncEnd))
      else $error("vsync low outside its window");

   // Idle bus floats high
   assert property (@(posedge clk7) disable iff (!rst_n)
      iorqN |-> (dout == 8'hFF))
      else $error("dout not FF while iorqN is high");

endmodule

bind ulaPlusTop ulaPlusProperties props0 (
   .clk7 (clk7), .rst_n (rst_n), .hc (hc), .vc (vc), .intN (intN),
   .hsync (hsync), .vsync (vsync), .iorqN (iorqN), .dout (dout)
);

`default_nettype wire

// File: tbUlaPlus.sv
`timescale 1ns/1ps
`default_nettype none

module tbUlaPlus;

   localparam int frameCycles = 139776;
   localparam int cycleLimit  = 40 * frameCycles;

   logic        clk7;
   logic        rst_n;
   logic [15:0] a;
   logic        iorqN;
   logic        rdN;
   logic        wrN;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        intN;
   logic [13:0] va;
   logic [7:0]  vramData;
   logic        ear;
   logic [4:0]  kbd;
   logic        issue2Keyboard;
   logic        mic;
   logic        spk;
   logic [2:0]  r;
   logic [2:0]  g;
   logic [2:0]  b;
   logic        hsync;
   logic        vsync;

   // Video RAM model and testbench copies of DUT state
   logic [7:0]   vram [0:16383];
   logic [7:0]   pal [0:63];
   logic [2:0]   tbBorder;
   logic         plusOnTb;
   logic [31:0]  lfsrState;
   logic [311:0] lineMask;
   // Raster position rebuilt from the sync edges
   logic [8:0]   tbHc;
   logic [8:0]   tbVc;
   logic [4:0]   tbFlash;
   logic         locked;
   logic         hsyncPrev;
   logic         vsyncPrev;
   logic [1:0]   syncExp;
   int           cycleCount;
   int           intFalls;
   int           testErrs;
   int           testsRun;
   int           testsFailed;
   string        curTest;

   ulaPlusTop dut0 (
      .clk7 (clk7), .rst_n (rst_n), .a (a), .iorqN (iorqN), .rdN (rdN), .wrN (wrN),
      .din (din), .dout (dout), .intN (intN), .va (va), .vramData (vramData),
      .ear (ear), .kbd (kbd), .issue2Keyboard (issue2Keyboard), .mic (mic), .spk (spk),
      .r (r), .g (g), .b (b), .hsync (hsync), .vsync (vsync)
   );

   // 8 ns clock
   always #4 clk7 = !clk7;

   // Combinational VRAM answer
   assign vramData = vram[va];

   //////////////////////////////////////////////////
   // Helpers
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0001) : (s >> 1);
   endfunction

   // One LFSR step per bit
   task automatic nextByte(output logic [7:0] v);
      v = 8'h00;
      for (int i = 0; i < 8; i++) begin
         v = {v[6:0], lfsrState[0]};
         lfsrState = lfsrNext(lfsrState);
      end
   endtask

   // Expected GRB for a raster position
   function automatic logic [8:0] refColour(input logic [8:0] hcS, input logic [8:0] vcS);
      logic [8:0] x;
      logic [7:0] bits;
      logic [7:0] attr;
      logic       px;
      logic [2:0] idx;
      logic [2:0] lvl;
      logic [7:0] entry;
      if (hcS >= 9'd344 && hcS <= 9'd375) begin
         return 9'd0;
      end
      if (vcS < 9'd192 && hcS >= 9'd13 && hcS <= 9'd268) begin
         x = hcS - 9'd13;
         bits = vram[{1'b0, vcS[7:6], vcS[2:0], vcS[5:3], x[7:3]}];
         attr = vram[{1'b0, 3'b110, vcS[7:3], x[7:3]}];
         // Flash phase flips ink and paper
         px = bits[3'd7 - x[2:0]] ^ (attr[7] & tbFlash[4]);
      end else begin
         attr = {2'b00, tbBorder, 3'b000};
         px = 1'b0;
      end
      if (plusOnTb) begin
         entry = px ? pal[{attr[7:6], 1'b0, attr[2:0]}] : pal[{attr[7:6], 1'b1, attr[5:3]}];
         return {entry, entry[1]};
      end
      idx = px ? attr[2:0] : attr[5:3];
      lvl = attr[6] ? 3'b111 : 3'b101;
      return {idx[2] ? lvl : 3'b000, idx[1] ? lvl : 3'b000, idx[0] ? lvl : 3'b000};
   endfunction

   task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (exp == act) else begin
         $display("ERR %s %s expected %h actual %h", curTest, what, exp, act);
         testErrs++;
      end
   endtask

   task automatic finishTest();
      testsRun++;
      if (testErrs != 0) begin
         testsFailed++;
      end
      $display("Test %s: %0d errors", curTest, testErrs);
      testErrs = 0;
   endtask

   // Z80 style I/O cycles, one clock each
   task automatic ioWrite(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clk7);
      a <= addr;
      din <= data;
      iorqN <= 1'b0;
      wrN <= 1'b0;
      @(posedge clk7);
      iorqN <= 1'b1;
      wrN <= 1'b1;
   endtask

   task automatic ioRead(input logic [15:0] addr, output logic [7:0] data);
      @(posedge clk7);
      a <= addr;
      iorqN <= 1'b0;
      rdN <= 1'b0;
      @(negedge clk7);
      data = dout;
      @(posedge clk7);
      iorqN <= 1'b1;
      rdN <= 1'b1;
   endtask

   // Compare the selected lines over one whole frame
   task automatic runLineCheck(input logic [311:0] mask);
      @(negedge vsync);
      lineMask = mask;
      @(negedge vsync);
      lineMask = '0;
   endtask

   //////////////////////////////////////////////////
   // Raster tracking and pixel compare
   always @(negedge clk7) begin
      if (!rst_n) begin
         locked = 1'b0;
         tbFlash = 5'd0;
      end else begin
         tbHc = (tbHc == 9'd447) ? 9'd0 : tbHc + 9'd1;
         if (tbHc == 9'd0) begin
            tbVc = (tbVc == 9'd311) ? 9'd0 : tbVc + 9'd1;
         end
         // Sync levels from the free-running position
         if (locked) begin
            syncExp = {!((tbHc >= 9'd344) && (tbHc <= 9'd375)),
                       !((tbVc >= 9'd248) && (tbVc <= 9'd251))};
            assert ({hsync, vsync} == syncExp) else begin
               $display("ERR %s sync hc %0d vc %0d expected %b actual %b", curTest,
                        tbHc, tbVc, syncExp, {hsync, vsync});
               testErrs++;
            end
         end
         if (hsyncPrev && !hsync) begin
            tbHc = 9'd344;
         end
         if (vsyncPrev && !vsync) begin
            tbHc = 9'd0;
            tbVc = 9'd248;
            locked = 1'b1;
         end
         if (locked && lineMask[tbVc]) begin
            assert ({g, r, b} == refColour(tbHc, tbVc)) else begin
               $display("ERR %s pixel hc %0d vc %0d expected %h actual %h", curTest,
                        tbHc, tbVc, refColour(tbHc, tbVc), {g, r, b});
               testErrs++;
            end
         end
         // DUT flash counter steps on the next edge
         if (locked && tbVc == 9'd248 && tbHc == 9'd0) begin
            tbFlash = tbFlash + 5'd1;
         end
      end
      hsyncPrev = hsync;
      vsyncPrev = vsync;
   end

   always @(negedge intN) begin
      intFalls++;
   end

   // Run limit
   always @(posedge clk7) begin
      cycleCount++;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: the run went past its cycle limit");
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   initial begin
      logic [311:0] mask;
      logic [7:0]   v;
      logic [7:0]   rd;
      logic         pe;
      int           delay;
      int           width;
      int           falls;
      int           flashCells;
      clk7 = 1'b0;
      rst_n = 1'b0;
      a = 16'hFFFF;
      iorqN = 1'b1;
      rdN = 1'b1;
      wrN = 1'b1;
      din = 8'h00;
      ear = 1'b0;
      kbd = 5'h1F;
      issue2Keyboard = 1'b0;
      lfsrState = 32'hbd78_166e;
      lineMask = '0;
      tbHc = 9'd0;
      tbVc = 9'd0;
      tbBorder = 3'b010;
      plusOnTb = 1'b0;
      locked = 1'b0;
      tbFlash = 5'd0;
      hsyncPrev = 1'b1;
      vsyncPrev = 1'b1;
      syncExp = 2'b11;
      cycleCount = 0;
      intFalls = 0;
      testErrs = 0;
      testsRun = 0;
      testsFailed = 0;
      for (int i = 0; i < 16384; i++) begin
         nextByte(v);
         vram[i] = v;
      end
      for (int i = 0; i < 64; i++) begin
         pal[i] = 8'h00;
      end
      repeat (8) @(posedge clk7);
      rst_n <= 1'b1;

      // Border colour 5 with speaker and MIC set
      curTest = "border";
      ioWrite(16'h00FE, 8'h1D);
      tbBorder = 3'd5;
      // Port outputs settle after the write edge
      @(negedge clk7);
      checkValue("spk", 32'(1'b1), 32'(spk));
      checkValue("mic", 32'(1'b1), 32'(mic));
      mask = '0;
      for (int i = 200; i <= 240; i++) begin
         mask[i] = 1'b1;
      end
      runLineCheck(mask);
      finishTest();

      // Standard paper on three lines
      curTest = "paper";
      mask = '0;
      mask[0] = 1'b1;
      mask[97] = 1'b1;
      mask[191] = 1'b1;
      runLineCheck(mask);
      finishTest();

      // Palette, config and register readback
      curTest = "plusRegs";
      for (int i = 0; i < 64; i++) begin
         ioWrite(16'hBF3B, 8'(i));
         nextByte(v);
         ioWrite(16'hFF3B, v);
         pal[i] = v;
      end
      for (int i = 0; i < 64; i++) begin
         ioWrite(16'hBF3B, 8'(i));
         ioRead(16'hFF3B, rd);
         checkValue("entry", 32'(pal[i]), 32'(rd));
      end
      ioWrite(16'hBF3B, 8'h40);
      ioWrite(16'hFF3B, 8'hFE);
      ioRead(16'hFF3B, rd);
      checkValue("config", 32'h02, 32'(rd));
      ioWrite(16'hBF3B, 8'hC5);
      ioRead(16'hBF3B, rd);
      checkValue("palReg", 32'h45, 32'(rd));
      finishTest();

      // ULAplus colours on the screen
      curTest = "plusDisplay";
      ioWrite(16'hBF3B, 8'h40);
      ioWrite(16'hFF3B, 8'h01);
      plusOnTb = 1'b1;
      mask = '0;
      mask[5] = 1'b1;
      mask[100] = 1'b1;
      mask[180] = 1'b1;
      mask[220] = 1'b1;
      runLineCheck(mask);
      finishTest();

      // INT position, width and rate
      curTest = "interrupt";
      for (int f = 0; f < 2; f++) begin
         @(negedge vsync);
         falls = intFalls;
         delay = 0;
         do begin
            @(negedge clk7);
            if (intN) begin
               delay++;
            end
         end while (intN);
         width = 0;
         while (!intN) begin
            width++;
            @(negedge clk7);
         end
         checkValue("intDelay", 32'(2), 32'(delay));
         checkValue("intWidth", 32'(64), 32'(width));
         @(negedge vsync);
         checkValue("intPerFrame", 32'(1), 32'(intFalls - falls));
      end
      finishTest();

      // Flash swap in standard mode, then keyboard reads
      curTest = "flashKbd";
      ioWrite(16'hBF3B, 8'h40);
      ioWrite(16'hFF3B, 8'h00);
      plusOnTb = 1'b0;
      ioWrite(16'h00FE, 8'h0D);
      flashCells = 0;
      for (int i = 6144; i < 6912; i++) begin
         if (vram[i][7]) begin
            flashCells++;
         end
      end
      assert (flashCells > 0) else begin
         $display("VRAM holds no flash cell to test");
         testErrs++;
      end
      wait (tbFlash[4] == 1'b1);
      mask = '0;
      for (int i = 0; i < 192; i++) begin
         mask[i] = 1'b1;
      end
      runLineCheck(mask);
      for (int k = 0; k < 8; k++) begin
         nextByte(v);
         @(posedge clk7);
         // Issue 2 setting alternates between reads
         issue2Keyboard <= k[0];
         ear <= v[6];
         kbd <= v[4:0];
         ioRead(16'h7FFE, rd);
         // MIC is set and speaker clear here
         pe = k[0] ? (v[6] ^ 1'b1) : v[6];
         checkValue("kbdRead", 32'({1'b1, pe, 1'b1, v[4:0]}), 32'(rd));
      end
      finishTest();

      $display("Tests run %0d, failed %0d", testsRun, testsFailed);
      if (testsFailed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: ulaPlus.f
ulaTimingPkg.sv
ulaPortPkg.sv
rasterCounter.sv
videoFetch.sv
colourPalette.sv
cpuPorts.sv
ulaPlusTop.sv
ulaPlus_properties.sv
tbUlaPlus.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the ulaPlus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tbUlaPlus \
   -f ulaPlus.f -Mdir objDir -o simUlaPlus
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./objDir/simUlaPlus > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
   echo "Simulation exited with status $runStatus"
   exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
   exit 0
else
   echo "Pass message not found in sim.log"
   exit 1
fi
